// ==== dl11_baud_gen.sv ====
/*
 * baud rate generator, one counter chain gives the 16x receive
 * sample tick and the transmit bit tick so both stay in phase
 */

`timescale 1ns/100ps

module dl11_baud_gen #(
   parameter int CLKS_PER_BIT = 32
) (
   input  logic clk,
   input  logic reset,
   output logic tx_tick,
   output logic rx_tick
);

   localparam int DIV   = CLKS_PER_BIT / 16;
   localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       sub_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         sub_cnt <= '0;
      end
      else if (rx_tick)
      begin
         div_cnt <= '0;
         sub_cnt <= sub_cnt + 4'd1;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign rx_tick = (div_cnt == DIV_W'(DIV - 1));
   // every sixteenth sample tick closes a bit period
   assign tx_tick = rx_tick && (sub_cnt == 4'd15);

   // sixteen sample ticks must add up to exactly one bit period
   a_tick_lock: assert property (@(posedge clk) disable iff (reset)
      $past(tx_tick, CLKS_PER_BIT) |-> tx_tick);

endmodule

// ==== dl11_pkg.sv ====
/*
 * shared types and constants for the DL11 console serial line unit
 * import into any module that touches the bus, the UART state machines
 * or the interrupt
 */

package dl11_pkg;

   // register select, taken from address bits [2:1]
   typedef enum logic [1:0] {
      RCSR = 2'd0,
      RBUF = 2'd1,
      XCSR = 2'd2,
      XBUF = 2'd3
   } reg_sel_e;

   // transmitter FSM
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_DATA  = 2'd2,
      TX_STOP  = 2'd3
   } tx_state_e;

   // receiver FSM
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,
      RX_START = 2'd1,
      RX_DATA  = 2'd2,
      RX_STOP  = 2'd3
   } rx_state_e;

   // one I/O page access
   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic        rd;
      logic        wr;
   } iopage_req_t;

   // character from the receiver, valid is a one-cycle pulse
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } rx_char_t;

   // character to the transmitter, load is a one-cycle pulse
   typedef struct packed {
      logic       load;
      logic [7:0] data;
   } tx_load_t;

   typedef struct packed {
      logic       request;
      logic [7:0] vector;
   } intr_t;

   localparam logic [12:0] DL11_BASE = 13'o17560;
   localparam logic [7:0]  VEC_RX    = 8'o060;
   localparam logic [7:0]  VEC_TX    = 8'o064;

endpackage

// ==== dl11_regs.sv ====
/*
 * DL11 register block on the I/O page: RCSR, RBUF, XCSR and XBUF
 * reads are combinational from the address, writes land on the next edge
 * also forms the prioritized interrupt request and vector
 */

`timescale 1ns/100ps

module dl11_regs import dl11_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  iopage_req_t req,
   input  rx_char_t    rx_char,
   input  logic        tx_busy,
   output logic [15:0] data_out,
   output logic        decode,
   output tx_load_t    tx_load,
   output intr_t       intr
);

   reg_sel_e    sel;
   logic        wr_en;
   logic        rd_en;
   logic [7:0]  rbuf;
   logic [15:0] xbuf;
   logic        rx_done;
   logic        tx_ready;
   logic        rx_ie;
   logic        tx_ie;
   logic        load_q;
   logic        tx_busy_q;
   logic        tx_fall;
   logic        rx_term;
   logic        tx_term;

   // four even word addresses starting at the base
   assign decode = (req.addr[12:3] == DL11_BASE[12:3]) && !req.addr[0];
   assign sel    = reg_sel_e'(req.addr[2:1]);
   assign wr_en  = req.wr && decode;
   assign rd_en  = req.rd && decode;

   always_comb
   begin
      data_out = 16'h0000;
      if (decode)
      begin
         case (sel)
            RCSR:    data_out = {8'h00, rx_done, rx_ie, 6'b000000};
            RBUF:    data_out = {8'h00, rbuf};
            XCSR:    data_out = {8'h00, tx_ready, tx_ie, 6'b000000};
            XBUF:    data_out = xbuf;
            default: data_out = 16'h0000;
         endcase
      end
   end

   assign tx_fall = tx_busy_q && !tx_busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_done   <= 1'b0;
         tx_ready  <= 1'b1;
         rx_ie     <= 1'b0;
         tx_ie     <= 1'b0;
         load_q    <= 1'b0;
         tx_busy_q <= 1'b0;
      end
      else
      begin
         tx_busy_q <= tx_busy;
         load_q    <= 1'b0;

         if (wr_en && sel == RCSR)
            rx_ie <= req.wdata[6];
         if (wr_en && sel == XCSR)
            tx_ie <= req.wdata[6];

         // an XBUF write only starts a character while ready
         if (wr_en && sel == XBUF && tx_ready)
         begin
            load_q   <= 1'b1;
            tx_ready <= 1'b0;
         end
         else if (tx_fall)
            tx_ready <= 1'b1;

         // a new character wins over a read in the same cycle
         if (rx_char.valid)
            rx_done <= 1'b1;
         else if (rd_en && sel == RBUF)
            rx_done <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en && sel == XBUF)
         xbuf <= req.wdata;
      // no overrun flag, a late character simply overwrites
      if (rx_char.valid)
         rbuf <= rx_char.data;
   end

   assign tx_load = '{load: load_q, data: xbuf[7:0]};

   assign rx_term = rx_ie && rx_done;
   assign tx_term = tx_ie && tx_ready;

   // receiver has priority
   assign intr.request = rx_term || tx_term;
   assign intr.vector  = rx_term ? VEC_RX :
                         tx_term ? VEC_TX :
                         8'h00;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(req.rd && req.wr));

endmodule

// ==== dl11_top.f ====
dl11_pkg.sv
dl11_baud_gen.sv
dl11_uart_rx.sv
dl11_uart_tx.sv
dl11_regs.sv
dl11_top.sv
tb_dl11_top.sv

// ==== dl11_top.sv ====
/*
 * DL11 console serial line unit, ties the I/O page registers to the
 * baud generator and the 8N1 receiver and transmitter
 * CLKS_PER_BIT sets the bit period and must be a multiple of 16
 */

`timescale 1ns/100ps

module dl11_top import dl11_pkg::*; #(
   parameter int CLKS_PER_BIT = 32
) (
   input  logic        clk,
   input  logic        reset,
   input  iopage_req_t req,
   input  logic        rs232_rx,
   output logic [15:0] data_out,
   output logic        decode,
   output intr_t       intr,
   output logic        rs232_tx
);

   tx_load_t tx_load;
   rx_char_t rx_char;
   logic     tx_busy;
   logic     tx_tick;
   logic     rx_tick;

   dl11_regs u_regs (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .rx_char  (rx_char),
      .tx_busy  (tx_busy),
      .data_out (data_out),
      .decode   (decode),
      .tx_load  (tx_load),
      .intr     (intr)
   );

   dl11_baud_gen #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_baud_gen (
      .clk     (clk),
      .reset   (reset),
      .tx_tick (tx_tick),
      .rx_tick (rx_tick)
   );

   dl11_uart_rx u_uart_rx (
      .clk      (clk),
      .reset    (reset),
      .rx_tick  (rx_tick),
      .rs232_rx (rs232_rx),
      .rx_char  (rx_char)
   );

   dl11_uart_tx u_uart_tx (
      .clk      (clk),
      .reset    (reset),
      .tx_tick  (tx_tick),
      .tx_load  (tx_load),
      .rs232_tx (rs232_tx),
      .tx_busy  (tx_busy)
   );

endmodule

// ==== dl11_uart_rx.sv ====
/*
 * 8N1 receiver, samples the line on the 16x tick, confirms the start
 * bit at mid-bit and delivers each good character as a one-cycle pulse
 * a frame with a low stop bit is dropped
 */

`timescale 1ns/100ps

module dl11_uart_rx import dl11_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     rx_tick,
   input  logic     rs232_rx,
   output rx_char_t rx_char
);

   rx_state_e  state;
   logic       rx_meta;
   logic       rx_sync;
   logic [3:0] tick_cnt;
   logic [2:0] bit_cnt;
   logic [7:0] shreg;
   logic       valid_q;
   logic       sample_bit;

   // mid-bit of a data bit
   assign sample_bit = rx_tick && (state == RX_DATA) && (tick_cnt == 4'd15);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta  <= 1'b1;
         rx_sync  <= 1'b1;
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         valid_q  <= 1'b0;
      end
      else
      begin
         rx_meta <= rs232_rx;
         rx_sync <= rx_meta;
         valid_q <= 1'b0;
         if (rx_tick)
         begin
            case (state)
               RX_IDLE:
               begin
                  tick_cnt <= '0;
                  if (!rx_sync)
                     state <= RX_START;
               end
               RX_START:
               begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd7)
                  begin
                     // still low at mid-start, otherwise it was a glitch
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     state    <= rx_sync ? RX_IDLE : RX_DATA;
                  end
               end
               RX_DATA:
               begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd15)
                  begin
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7)
                        state <= RX_STOP;
                  end
               end
               RX_STOP:
               begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd15)
                  begin
                     valid_q <= rx_sync;
                     state   <= RX_IDLE;
                  end
               end
               default: state <= RX_IDLE;
            endcase
         end
      end
   end

   // data arrives LSB first
   always_ff @(posedge clk)
   begin
      if (sample_bit)
         shreg <= {rx_sync, shreg[7:1]};
   end

   assign rx_char = '{valid: valid_q, data: shreg};

endmodule

// ==== dl11_uart_tx.sv ====
/*
 * 8N1 transmitter, takes one character on a load pulse and shifts it
 * out on the bit tick, tx_busy stays high until the stop bit ends
 */

`timescale 1ns/100ps

module dl11_uart_tx import dl11_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     tx_tick,
   input  tx_load_t tx_load,
   output logic     rs232_tx,
   output logic     tx_busy
);

   tx_state_e  state;
   logic [3:0] bit_cnt;
   logic [7:0] shreg;
   logic       accept;
   logic       shift;

   assign accept = tx_load.load && (state == TX_IDLE);
   assign shift  = tx_tick && (state == TX_DATA) && (bit_cnt != 4'd8);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= TX_IDLE;
         bit_cnt  <= '0;
         rs232_tx <= 1'b1;
      end
      else if (accept)
      begin
         state <= TX_START;
      end
      else if (tx_tick)
      begin
         case (state)
            TX_START:
            begin
               rs232_tx <= 1'b0;
               bit_cnt  <= '0;
               state    <= TX_DATA;
            end
            TX_DATA:
            begin
               // counts 0..7 are data bits, 8 puts out the stop bit
               bit_cnt <= bit_cnt + 4'd1;
               if (bit_cnt == 4'd8)
               begin
                  rs232_tx <= 1'b1;
                  state    <= TX_STOP;
               end
               else
                  rs232_tx <= shreg[0];
            end
            TX_STOP:  state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         shreg <= tx_load.data;
      else if (shift)
         shreg <= {1'b0, shreg[7:1]};
   end

   assign tx_busy = (state != TX_IDLE);

   // the register block only loads when its ready flag is set
   a_no_load_busy: assert property (@(posedge clk) disable iff (reset)
      tx_load.load |-> !tx_busy);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the DL11 testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module tb_dl11_top \
      -f dl11_top.f -o sim_dl11; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_dl11 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb_dl11_top.sv ====
/*
 * testbench for the DL11 serial line unit, acts as bus master on the
 * I/O page and as the remote terminal on both serial lines
 * steps come from a table that is built at start and applied in a loop
 */

`timescale 1ns/100ps

module tb_dl11_top import dl11_pkg::*; ();

   localparam int CLKS_PER_BIT = 32;
   localparam int FRAME_LIMIT  = 12 * CLKS_PER_BIT;
   localparam int unsigned SEED = 58913;

   typedef enum logic [2:0] {
      OP_READ, OP_WRITE, OP_DECODE, OP_SEND, OP_EXPECT, OP_WAIT, OP_INTR
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [12:0] addr;
      logic [15:0] data;
      logic [15:0] exp_val;
   } step_t;

   localparam iopage_req_t IDLE_REQ = '{addr: 13'd0, wdata: 16'd0, rd: 1'b0, wr: 1'b0};

   logic        clk;
   logic        reset;
   iopage_req_t req;
   logic        rs232_rx;
   logic [15:0] data_out;
   logic        decode;
   intr_t       intr;
   logic        rs232_tx;

   step_t       steps[$];
   logic [8:0]  frame_q[$];
   int          checks;
   int          mismatches;
   int          timeouts;

   // terminal side receive model
   logic        mon_busy;
   int          mon_cnt;
   logic [3:0]  bit_idx;
   logic [9:0]  mon_frame;

   dl11_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_dl11_top (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .rs232_rx (rs232_rx),
      .data_out (data_out),
      .decode   (decode),
      .intr     (intr),
      .rs232_tx (rs232_tx)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // start edge found on a falling clock, each bit sampled at its middle
   always @(negedge clk)
   begin
      if (reset)
         mon_busy = 1'b0;
      else if (!mon_busy)
      begin
         if (rs232_tx == 1'b0)
         begin
            mon_busy = 1'b1;
            mon_cnt  = CLKS_PER_BIT / 2;
            bit_idx  = 4'd0;
         end
      end
      else
      begin
         mon_cnt = mon_cnt - 1;
         if (mon_cnt == 0)
         begin
            mon_frame[bit_idx] = rs232_tx;
            mon_cnt = CLKS_PER_BIT;
            if (bit_idx == 4'd9)
            begin
               // framing is good with start low and stop high
               frame_q.push_back({!mon_frame[0] && mon_frame[9], mon_frame[8:1]});
               mon_busy = 1'b0;
            end
            bit_idx = bit_idx + 4'd1;
         end
      end
   end

   // I/O page addresses of the four DL11 registers
   function automatic logic [12:0] reg_addr(input reg_sel_e sel);
      case (sel)
         RCSR:    return 13'o17560;
         RBUF:    return 13'o17562;
         XCSR:    return 13'o17564;
         default: return 13'o17566;
      endcase
   endfunction

   function automatic void add_step(input op_e op, input logic [12:0] addr,
                                    input logic [15:0] data, input logic [15:0] exp_val);
      step_t s;
      s = '{op: op, addr: addr, data: data, exp_val: exp_val};
      steps.push_back(s);
   endfunction

   task automatic compare_value(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
      checks++;
      if (actual !== expected)
      begin
         mismatches++;
         $display("FAILED %s: actual %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic bus_access(input logic [12:0] addr, input logic [15:0] wdata,
                             input logic rd, input logic wr, input logic [15:0] exp_val);
      @(posedge clk);
      #1;
      req = '{addr: addr, wdata: wdata, rd: rd, wr: wr};
      #2;
      if (rd)
         compare_value("data_out", data_out, exp_val);
      else if (!wr)
         compare_value("decode", {15'd0, decode}, exp_val);
      @(posedge clk);
      #1;
      req = IDLE_REQ;
   endtask

   task automatic send_serial(input logic [7:0] ch, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, ch, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         #1;
         rs232_rx = frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
      @(posedge clk);
      #1;
      rs232_rx = 1'b1;
   endtask

   task automatic expect_serial(input logic [7:0] exp_ch);
      int         cycles;
      logic [8:0] got;
      cycles = 0;
      while (frame_q.size() == 0 && cycles < FRAME_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (frame_q.size() == 0)
      begin
         timeouts++;
         $display("timeout while waiting for a character on rs232_tx");
      end
      else
      begin
         got = frame_q.pop_front();
         compare_value("rs232_tx data", {8'd0, got[7:0]}, {8'd0, exp_ch});
         compare_value("rs232_tx framing", {15'd0, got[8]}, 16'h0001);
      end
   endtask

   // polls bit 7 of a CSR without a read strobe
   task automatic wait_flag(input logic [12:0] addr, input logic flag);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #1;
      req = '{addr: addr, wdata: 16'd0, rd: 1'b0, wr: 1'b0};
      #1;
      while (data_out[7] !== flag && cycles < FRAME_LIMIT)
      begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (data_out[7] !== flag)
      begin
         timeouts++;
         $display("timeout while waiting for the flag at address %o", addr);
      end
      @(posedge clk);
      #1;
      req = IDLE_REQ;
   endtask

   task automatic check_intr(input logic [15:0] exp_val);
      @(posedge clk);
      #2;
      compare_value("intr", {7'd0, intr.request, intr.vector}, exp_val);
   endtask

   task automatic run_step(input step_t s);
      case (s.op)
         OP_READ:   bus_access(s.addr, 16'd0, 1'b1, 1'b0, s.exp_val);
         OP_WRITE:  bus_access(s.addr, s.data, 1'b0, 1'b1, 16'd0);
         OP_DECODE: bus_access(s.addr, 16'd0, 1'b0, 1'b0, s.exp_val);
         // data bit 8 asks for a low stop bit
         OP_SEND:   send_serial(s.data[7:0], !s.data[8]);
         OP_EXPECT: expect_serial(s.exp_val[7:0]);
         OP_WAIT:   wait_flag(s.addr, s.exp_val[0]);
         OP_INTR:   check_intr(s.exp_val);
         default:
         begin
            mismatches++;
            $display("unknown operation in the step table");
         end
      endcase
   endtask

   task automatic build_table();
      logic [15:0] word;
      logic [7:0]  ch;
      // reset values and address decode
      add_step(OP_READ, reg_addr(XCSR), 16'd0, 16'o200);
      add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'd0);
      add_step(OP_INTR, 13'd0, 16'd0, 16'd0);
      add_step(OP_DECODE, reg_addr(RCSR), 16'd0, 16'd1);
      add_step(OP_DECODE, reg_addr(RBUF), 16'd0, 16'd1);
      add_step(OP_DECODE, reg_addr(XCSR), 16'd0, 16'd1);
      add_step(OP_DECODE, reg_addr(XBUF), 16'd0, 16'd1);
      add_step(OP_DECODE, DL11_BASE + 13'o10, 16'd0, 16'd0);
      add_step(OP_READ, DL11_BASE + 13'o10, 16'd0, 16'd0);
      add_step(OP_DECODE, DL11_BASE - 13'o2, 16'd0, 16'd0);
      add_step(OP_READ, DL11_BASE - 13'o2, 16'd0, 16'd0);
      add_step(OP_DECODE, DL11_BASE + 13'o1, 16'd0, 16'd0);
      // interrupt enables
      add_step(OP_WRITE, reg_addr(RCSR), 16'o100, 16'd0);
      add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'o100);
      add_step(OP_WRITE, reg_addr(XCSR), 16'o100, 16'd0);
      add_step(OP_READ, reg_addr(XCSR), 16'd0, 16'o300);
      add_step(OP_INTR, 13'd0, 16'd0, {7'd0, 1'b1, 8'o064});
      add_step(OP_WRITE, reg_addr(XCSR), 16'd0, 16'd0);
      add_step(OP_INTR, 13'd0, 16'd0, 16'd0);
      add_step(OP_WRITE, reg_addr(RCSR), 16'd0, 16'd0);
      add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'd0);
      // transmit
      for (int i = 0; i < 2; i++)
      begin
         word = 16'($urandom);
         add_step(OP_WRITE, reg_addr(XBUF), word, 16'd0);
         add_step(OP_READ, reg_addr(XCSR), 16'd0, 16'd0);
         add_step(OP_READ, reg_addr(XBUF), 16'd0, word);
         add_step(OP_EXPECT, 13'd0, 16'd0, {8'd0, word[7:0]});
         add_step(OP_WAIT, reg_addr(XCSR), 16'd0, 16'd1);
         add_step(OP_READ, reg_addr(XCSR), 16'd0, 16'o200);
      end
      // receive
      for (int i = 0; i < 2; i++)
      begin
         ch = 8'($urandom);
         add_step(OP_SEND, 13'd0, {8'd0, ch}, 16'd0);
         add_step(OP_WAIT, reg_addr(RCSR), 16'd0, 16'd1);
         add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'o200);
         add_step(OP_READ, reg_addr(RBUF), 16'd0, {8'd0, ch});
         add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'd0);
      end
      // low stop bit, the old character stays in RBUF
      add_step(OP_SEND, 13'd0, {7'd0, 1'b1, ~ch}, 16'd0);
      add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'd0);
      add_step(OP_READ, reg_addr(RBUF), 16'd0, {8'd0, ch});
      // receiver vector wins over transmitter
      ch = 8'($urandom);
      add_step(OP_WRITE, reg_addr(RCSR), 16'o100, 16'd0);
      add_step(OP_WRITE, reg_addr(XCSR), 16'o100, 16'd0);
      add_step(OP_INTR, 13'd0, 16'd0, {7'd0, 1'b1, 8'o064});
      add_step(OP_SEND, 13'd0, {8'd0, ch}, 16'd0);
      add_step(OP_WAIT, reg_addr(RCSR), 16'd0, 16'd1);
      add_step(OP_INTR, 13'd0, 16'd0, {7'd0, 1'b1, 8'o060});
      add_step(OP_READ, reg_addr(RCSR), 16'd0, 16'o300);
      add_step(OP_READ, reg_addr(RBUF), 16'd0, {8'd0, ch});
      add_step(OP_INTR, 13'd0, 16'd0, {7'd0, 1'b1, 8'o064});
      add_step(OP_WRITE, reg_addr(RCSR), 16'd0, 16'd0);
      add_step(OP_WRITE, reg_addr(XCSR), 16'd0, 16'd0);
      add_step(OP_INTR, 13'd0, 16'd0, 16'd0);
   endtask

   initial
   begin
      checks     = 0;
      mismatches = 0;
      timeouts   = 0;
      reset      = 1'b1;
      req        = IDLE_REQ;
      rs232_rx   = 1'b1;
      void'($urandom(SEED));
      build_table();
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      compare_value("rs232_tx", {15'd0, rs232_tx}, 16'h0001);
      foreach (steps[i])
         run_step(steps[i]);
      if (frame_q.size() != 0)
      begin
         mismatches++;
         $display("unexpected characters were sent on rs232_tx");
      end
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule
